//--- common/execPipe_config.svh
`ifndef EXECPIPE_CONFIG_SVH
`define EXECPIPE_CONFIG_SVH

//////////////////////////////////////////////////
// datapath sizing
//////////////////////////////////////////////////

`define DATA_W 16 // register and alu width
`define REG_N 16 // general purpose registers

// psr after reset, bit order CLFZN
`define PSR_RST 5'b00000

`endif

//--- common/isaPkg.sv
package isaPkg;

    //////////////////////////////////////////////////
    // major opcode, instr[15:12]
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_REG   = 4'b0000, OP_ANDI  = 4'b0001, OP_ORI   = 4'b0010, OP_XORI  = 4'b0011,
        OP_SPEC  = 4'b0100, OP_ADDI  = 4'b0101, OP_ADDCI = 4'b0110, OP_ADDUI = 4'b0111,
        OP_SHIFT = 4'b1000, OP_SUBI  = 4'b1001, OP_SUBCI = 4'b1010, OP_CMPI  = 4'b1011,
        OP_BCOND = 4'b1100, OP_MOVI  = 4'b1101, OP_MULI  = 4'b1110, OP_LUI   = 4'b1111
    } opcodeT;

    // function field, meaning depends on opcode
    typedef logic [3:0] funcT;

    // register ops
    localparam funcT FN_AND  = 4'b0001;
    localparam funcT FN_OR   = 4'b0010;
    localparam funcT FN_XOR  = 4'b0011;
    localparam funcT FN_NOT  = 4'b0100;
    localparam funcT FN_ADD  = 4'b0101;
    localparam funcT FN_ADDC = 4'b0110;
    localparam funcT FN_ADDU = 4'b0111;
    localparam funcT FN_SUB  = 4'b1001;
    localparam funcT FN_SUBC = 4'b1010;
    localparam funcT FN_CMP  = 4'b1011;
    localparam funcT FN_MOV  = 4'b1101;
    localparam funcT FN_MUL  = 4'b1110;
    localparam funcT FN_TEST = 4'b1111;
    // shift ops
    localparam funcT FN_LSHIL  = 4'b0000;
    localparam funcT FN_LSHIR  = 4'b0001;
    localparam funcT FN_ASHUIL = 4'b0010;
    localparam funcT FN_ASHUIR = 4'b0011;
    localparam funcT FN_LSH    = 4'b0100;
    localparam funcT FN_ASHU   = 4'b0110;
    // special ops, only scond is executed
    localparam funcT FN_SCOND  = 4'b1101;

    typedef enum logic [3:0] {
        CC_EQ, CC_NE, CC_CS, CC_CC, CC_HI, CC_LS, CC_GT, CC_LE,
        CC_FS, CC_FC, CC_LO, CC_HS, CC_LT, CC_GE, CC_UC, CC_NV
    } condT;

    // alu control, codes kept from the controller table
    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000, ALU_SUB  = 5'b00001, ALU_MUL  = 5'b00010,
        ALU_AND  = 5'b00011, ALU_OR   = 5'b00100, ALU_XOR  = 5'b00101,
        ALU_SCOND = 5'b00111, ALU_PASS = 5'b01000, ALU_LUI = 5'b01001,
        ALU_NOT  = 5'b01010, ALU_LSH  = 5'b01011, ALU_SHL  = 5'b01100,
        ALU_SHRL = 5'b01101, ALU_ASHU = 5'b01110, ALU_SHRA = 5'b01111
    } aluOpT;

    typedef struct packed {
        opcodeT     oper;  // 15:12
        logic [3:0] rdest; // 11:8
        funcT       func;  // 7:4, upper imm8 nibble
        logic [3:0] rsrc;  // 3:0, also scond condition
    } instrT;

endpackage

//--- common/pipePkg.sv
`include "execPipe_config.svh"

package pipePkg;

    // psr and flag enables share one layout
    typedef struct packed {
        logic c; // carry
        logic l; // unsigned less
        logic f; // signed overflow
        logic z; // zero
        logic n; // negative or signed less
    } flagsT;

    //////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        isaPkg::aluOpT      aluOp;
        flagsT              flagEn;
        logic               regWr;
        logic               useImm;    // src comes from imm
        logic               withCarry; // addc, subc and immediates
        isaPkg::condT       cond;
        logic [3:0]         rdest;
        logic [3:0]         rsrc;
        logic [`DATA_W-1:0] imm;
        logic               valid;
    } decodedT;

    typedef struct packed {
        isaPkg::aluOpT      aluOp;
        flagsT              flagEn;
        logic               regWr;
        logic               withCarry;
        isaPkg::condT       cond;
        logic [3:0]         rdest;
        logic [`DATA_W-1:0] dstVal;
        logic [`DATA_W-1:0] srcVal; // register or immediate
        logic               valid;
    } operandT;

    typedef struct packed {
        logic               regWr;
        logic [3:0]         rdest;
        logic [`DATA_W-1:0] result;
        logic               valid;
    } writebackT;

endpackage

//--- design/aluDecoder.sv
`timescale 1ns/1ps
`include "execPipe_config.svh"

module aluDecoder (
    input  isaPkg::instrT     instr,
    input  logic              instrValid,
    output pipePkg::decodedT  dec
);

    // flag enables, CLFZN
    localparam pipePkg::flagsT FE_ARITH = 5'b10111; // C F Z N
    localparam pipePkg::flagsT FE_CMP   = 5'b01011; // L Z N
    localparam pipePkg::flagsT FE_LOGIC = 5'b00010; // Z only

    logic [7:0]         imm8;
    logic [`DATA_W-1:0] immZx, immSx, shAmt;
    logic               wrOk; // opcode writes rdest

    assign imm8  = {instr.func, instr.rsrc};
    assign immZx = {{(`DATA_W-8){1'b0}}, imm8};
    assign immSx = {{(`DATA_W-8){imm8[7]}}, imm8};
    assign shAmt = {{(`DATA_W-4){1'b0}}, instr.rsrc}; // shift immediates

    //////////////////////////////////////////////////
    // opcode and function decode
    //////////////////////////////////////////////////

    always_comb begin
        // bubble by default
        dec.aluOp     = isaPkg::ALU_ADD;
        dec.flagEn    = '0;
        dec.useImm    = 1'b0;
        dec.withCarry = 1'b0;
        dec.imm       = immSx;
        wrOk          = 1'b0;

        case (instr.oper)
            isaPkg::OP_REG: begin
                wrOk = 1'b1;
                case (instr.func)
                    isaPkg::FN_AND: begin dec.aluOp = isaPkg::ALU_AND; dec.flagEn = FE_LOGIC; end
                    isaPkg::FN_OR:  begin dec.aluOp = isaPkg::ALU_OR;  dec.flagEn = FE_LOGIC; end
                    isaPkg::FN_XOR: begin dec.aluOp = isaPkg::ALU_XOR; dec.flagEn = FE_LOGIC; end
                    isaPkg::FN_NOT: begin dec.aluOp = isaPkg::ALU_NOT; dec.flagEn = FE_LOGIC; end
                    isaPkg::FN_ADD: dec.flagEn = FE_ARITH;
                    isaPkg::FN_ADDC: begin
                        dec.flagEn    = FE_ARITH;
                        dec.withCarry = 1'b1;
                    end
                    isaPkg::FN_ADDU: dec.aluOp = isaPkg::ALU_ADD; // no flags
                    isaPkg::FN_SUB: begin dec.aluOp = isaPkg::ALU_SUB; dec.flagEn = FE_ARITH; end
                    isaPkg::FN_SUBC: begin
                        dec.aluOp     = isaPkg::ALU_SUB;
                        dec.flagEn    = FE_ARITH;
                        dec.withCarry = 1'b1;
                    end
                    isaPkg::FN_CMP: begin
                        dec.aluOp  = isaPkg::ALU_SUB;
                        dec.flagEn = FE_CMP;
                        wrOk       = 1'b0; // flags only
                    end
                    isaPkg::FN_MOV: dec.aluOp = isaPkg::ALU_PASS;
                    isaPkg::FN_MUL: dec.aluOp = isaPkg::ALU_MUL;
                    isaPkg::FN_TEST: begin
                        dec.aluOp  = isaPkg::ALU_AND;
                        dec.flagEn = FE_LOGIC;
                        wrOk       = 1'b0;
                    end
                    default: wrOk = 1'b0; // unused func
                endcase
            end
            isaPkg::OP_SPEC: begin
                // jal, loads and stores stay bubbles
                if (instr.func == isaPkg::FN_SCOND) begin
                    dec.aluOp = isaPkg::ALU_SCOND;
                    wrOk      = 1'b1;
                end
            end
            isaPkg::OP_SHIFT: begin
                wrOk       = 1'b1;
                dec.useImm = 1'b1;
                case (instr.func)
                    isaPkg::FN_LSHIL,
                    isaPkg::FN_ASHUIL: begin dec.aluOp = isaPkg::ALU_SHL;  dec.imm = shAmt;  end
                    isaPkg::FN_LSHIR:  begin dec.aluOp = isaPkg::ALU_SHRL; dec.imm = -shAmt; end
                    isaPkg::FN_ASHUIR: begin dec.aluOp = isaPkg::ALU_SHRA; dec.imm = -shAmt; end
                    isaPkg::FN_LSH:    begin dec.aluOp = isaPkg::ALU_LSH;  dec.useImm = 1'b0; end
                    isaPkg::FN_ASHU:   begin dec.aluOp = isaPkg::ALU_ASHU; dec.useImm = 1'b0; end
                    default: begin
                        wrOk       = 1'b0;
                        dec.useImm = 1'b0;
                    end
                endcase
            end
            isaPkg::OP_BCOND: wrOk = 1'b0; // no branch unit
            isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI: begin
                wrOk       = 1'b1;
                dec.useImm = 1'b1;
                dec.imm    = immZx;
                dec.flagEn = FE_LOGIC;
                dec.aluOp  = (instr.oper == isaPkg::OP_ANDI) ? isaPkg::ALU_AND :
                             (instr.oper == isaPkg::OP_ORI)  ? isaPkg::ALU_OR : isaPkg::ALU_XOR;
            end
            isaPkg::OP_ADDI, isaPkg::OP_ADDCI, isaPkg::OP_ADDUI: begin
                wrOk          = 1'b1;
                dec.useImm    = 1'b1;
                dec.withCarry = (instr.oper == isaPkg::OP_ADDCI);
                dec.flagEn    = (instr.oper == isaPkg::OP_ADDUI) ? '0 : FE_ARITH;
            end
            isaPkg::OP_SUBI, isaPkg::OP_SUBCI, isaPkg::OP_CMPI: begin
                wrOk          = (instr.oper != isaPkg::OP_CMPI);
                dec.aluOp     = isaPkg::ALU_SUB;
                dec.useImm    = 1'b1;
                dec.withCarry = (instr.oper == isaPkg::OP_SUBCI);
                dec.flagEn    = (instr.oper == isaPkg::OP_CMPI) ? FE_CMP : FE_ARITH;
            end
            isaPkg::OP_MOVI: begin
                wrOk       = 1'b1;
                dec.aluOp  = isaPkg::ALU_PASS;
                dec.useImm = 1'b1;
                dec.imm    = immZx;
            end
            isaPkg::OP_MULI: begin
                wrOk       = 1'b1;
                dec.aluOp  = isaPkg::ALU_MUL;
                dec.useImm = 1'b1;
            end
            isaPkg::OP_LUI: begin
                wrOk       = 1'b1;
                dec.aluOp  = isaPkg::ALU_LUI;
                dec.useImm = 1'b1;
                dec.imm    = immZx; // alu moves it up a byte
            end
            default: wrOk = 1'b0;
        endcase

        dec.regWr = wrOk & instrValid; // invalid words never write
        dec.cond  = isaPkg::condT'(instr.rsrc);
        dec.rdest = instr.rdest;
        dec.rsrc  = instr.rsrc;
        dec.valid = instrValid;
    end

endmodule

//--- design/stageReg.sv
`timescale 1ns/1ps

// one pipeline register, reused for every stage payload
module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  payloadT d,
    output payloadT q
);

    //////////////////////////////////////////////////
    // payload flop
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0; // valid and control bits cleared
        end else begin
            q <= d; // new payload every cycle, no stall
        end
    end

endmodule

//--- design/operandRead.sv
`timescale 1ns/1ps
`include "execPipe_config.svh"

module operandRead (
    input  logic                clk,
    input  logic                arstN,
    input  pipePkg::decodedT    dec,
    input  pipePkg::writebackT  exFwd, // execute result, combinational
    input  pipePkg::writebackT  wbFwd, // writeback stage
    output pipePkg::operandT    opnd
);

    logic [`DATA_W-1:0] regs [`REG_N];
    logic [`DATA_W-1:0] dstFwd, srcFwd;

    //////////////////////////////////////////////////
    // register file, single write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wbFwd.valid && wbFwd.regWr) begin
            regs[wbFwd.rdest] <= wbFwd.result;
        end
    end

    // newest producer wins
    function automatic logic [`DATA_W-1:0] fwdSel(
        input logic [3:0]         addr,
        input pipePkg::writebackT ex,
        input pipePkg::writebackT wb,
        input logic [`DATA_W-1:0] rfVal
    );
        if (ex.valid && ex.regWr && ex.rdest == addr) begin
            return ex.result; // one ahead
        end else if (wb.valid && wb.regWr && wb.rdest == addr) begin
            return wb.result; // also covers same-cycle write
        end
        return rfVal;
    endfunction

    assign dstFwd = fwdSel(dec.rdest, exFwd, wbFwd, regs[dec.rdest]);
    assign srcFwd = fwdSel(dec.rsrc, exFwd, wbFwd, regs[dec.rsrc]);

    always_comb begin
        opnd.aluOp     = dec.aluOp;
        opnd.flagEn    = dec.flagEn;
        opnd.regWr     = dec.regWr;
        opnd.withCarry = dec.withCarry;
        opnd.cond      = dec.cond;
        opnd.rdest     = dec.rdest;
        opnd.dstVal    = dstFwd;
        opnd.srcVal    = dec.useImm ? dec.imm : srcFwd; // immediate forms
        opnd.valid     = dec.valid;
    end

endmodule

//--- alu/aluCore.sv
`timescale 1ns/1ps
`include "execPipe_config.svh"

module aluCore (
    input  logic               clk,
    input  logic               arstN,
    input  pipePkg::operandT   opnd,
    output pipePkg::writebackT wb,
    output pipePkg::flagsT     psr
);

    localparam int MSB = `DATA_W - 1;

    logic [MSB:0]   dst, src, srcB, negSrc, result;
    logic [MSB+1:0] sum;     // carry out on top
    logic           carryIn;
    logic           condTrue;
    pipePkg::flagsT flagsNew;

    assign dst    = opnd.dstVal;
    assign src    = opnd.srcVal;
    assign negSrc = -src; // right shift amount

    //////////////////////////////////////////////////
    // shared adder for add, sub and cmp
    //////////////////////////////////////////////////

    assign srcB    = (opnd.aluOp == isaPkg::ALU_SUB) ? ~src : src;
    // sub adds one, carry forms take stored C instead
    assign carryIn = opnd.withCarry ? psr.c : (opnd.aluOp == isaPkg::ALU_SUB);
    assign sum     = {1'b0, dst} + {1'b0, srcB} + carryIn;

    // scond condition against current psr
    always_comb begin
        case (opnd.cond)
            isaPkg::CC_EQ: condTrue = psr.z;
            isaPkg::CC_NE: condTrue = !psr.z;
            isaPkg::CC_CS: condTrue = psr.c;
            isaPkg::CC_CC: condTrue = !psr.c;
            isaPkg::CC_HI: condTrue = psr.l;
            isaPkg::CC_LS: condTrue = !psr.l;
            isaPkg::CC_GT: condTrue = psr.n;
            isaPkg::CC_LE: condTrue = !psr.n;
            isaPkg::CC_FS: condTrue = psr.f;
            isaPkg::CC_FC: condTrue = !psr.f;
            isaPkg::CC_LO: condTrue = !psr.z && !psr.l;
            isaPkg::CC_HS: condTrue = psr.z || psr.l;
            isaPkg::CC_LT: condTrue = !psr.z && !psr.n;
            isaPkg::CC_GE: condTrue = psr.z || psr.n;
            isaPkg::CC_UC: condTrue = 1'b1;
            default:       condTrue = 1'b0; // NV
        endcase
    end

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////

    always_comb begin
        case (opnd.aluOp)
            isaPkg::ALU_ADD,
            isaPkg::ALU_SUB:   result = sum[MSB:0];
            isaPkg::ALU_MUL:   result = dst * src; // low half kept
            isaPkg::ALU_AND:   result = dst & src;
            isaPkg::ALU_OR:    result = dst | src;
            isaPkg::ALU_XOR:   result = dst ^ src;
            isaPkg::ALU_NOT:   result = ~dst;
            isaPkg::ALU_SCOND: result = {{MSB{1'b0}}, condTrue};
            isaPkg::ALU_PASS:  result = src;
            isaPkg::ALU_LUI:   result = src << 8;
            isaPkg::ALU_LSH:   result = src[MSB] ? dst >> negSrc[3:0] : dst << src[3:0];
            isaPkg::ALU_SHL:   result = dst << src[3:0];
            isaPkg::ALU_SHRL:  result = dst >> negSrc[4:0];
            isaPkg::ALU_ASHU: begin
                if (src[MSB]) begin
                    result = $signed(dst) >>> negSrc[3:0]; // sign bit fills in
                end else begin
                    result = dst << src[3:0];
                end
            end
            isaPkg::ALU_SHRA:  result = $signed(dst) >>> negSrc[4:0];
            default:           result = sum[MSB:0];
        endcase
    end

    // candidate flags, flagEn picks which land
    always_comb begin
        flagsNew.c = sum[MSB+1];
        flagsNew.l = dst < src; // unsigned compare
        flagsNew.f = (dst[MSB] == srcB[MSB]) && (sum[MSB] != dst[MSB]);
        flagsNew.z = (result == '0);
        // only cmp enables L, and there N means signed less
        flagsNew.n = opnd.flagEn.l ? ($signed(dst) < $signed(src)) : result[MSB];
    end

    //////////////////////////////////////////////////
    // psr, written with exReg
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            psr <= pipePkg::flagsT'(`PSR_RST);
        end else if (opnd.valid) begin
            psr <= (psr & ~opnd.flagEn) | (flagsNew & opnd.flagEn); // untouched bits hold
        end
    end

    assign wb.regWr  = opnd.regWr;
    assign wb.rdest  = opnd.rdest;
    assign wb.result = result;
    assign wb.valid  = opnd.valid;

endmodule

//--- design/execPipe.sv
`timescale 1ns/1ps
`include "execPipe_config.svh"

module execPipe (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    input  isaPkg::instrT      instr,
    output logic               wbValid,
    output logic [3:0]         wbAddr,
    output logic [`DATA_W-1:0] wbData,
    output pipePkg::flagsT     psr
);

    pipePkg::decodedT   decD, decQ;
    pipePkg::operandT   opD, opQ;
    pipePkg::writebackT exD, exQ;

    //////////////////////////////////////////////////
    // decode, read, execute, writeback
    //////////////////////////////////////////////////

    aluDecoder aluDecoder_inst (
        .instr      (instr),
        .instrValid (instrValid),
        .dec        (decD)
    );

    stageReg #(.payloadT(pipePkg::decodedT)) decReg (
        .clk(clk), .arstN(arstN), .d(decD), .q(decQ)
    );

    operandRead operandRead_inst (
        .clk   (clk),
        .arstN (arstN),
        .dec   (decQ),
        .exFwd (exD),  // execute bypass
        .wbFwd (exQ),  // writeback bypass and rf write
        .opnd  (opD)
    );

    stageReg #(.payloadT(pipePkg::operandT)) readReg (
        .clk(clk), .arstN(arstN), .d(opD), .q(opQ)
    );

    aluCore aluCore_inst (
        .clk   (clk),
        .arstN (arstN),
        .opnd  (opQ),
        .wb    (exD),
        .psr   (psr)
    );

    stageReg #(.payloadT(pipePkg::writebackT)) exReg (
        .clk(clk), .arstN(arstN), .d(exD), .q(exQ)
    );

    assign wbValid = exQ.valid & exQ.regWr; // the rf write this cycle
    assign wbAddr  = exQ.rdest;
    assign wbData  = exQ.result;

endmodule

//--- dv/execPipe_assert.sv
`timescale 1ns/1ps
`include "execPipe_config.svh"

// reference model and checks, bound into execPipe
module execPipe_assert (
    input logic               clk,
    input logic               arstN,
    input logic               instrValid,
    input isaPkg::instrT      instr,
    input logic               wbValid,
    input logic [3:0]         wbAddr,
    input logic [`DATA_W-1:0] wbData,
    input pipePkg::flagsT     psr
);

    typedef struct packed {
        logic               valid;
        logic [3:0]         addr;
        logic [`DATA_W-1:0] data;
        pipePkg::flagsT     psr;
    } expectT;

    logic [`DATA_W-1:0] shadowRf [`REG_N];
    pipePkg::flagsT     shadowPsr;
    expectT             line [3];   // three-deep delay line
    logic               nxtWr;
    logic [`DATA_W-1:0] nxtRes;
    pipePkg::flagsT     nxtPsr;
    int                 errCount = 0; // read by the testbench

    // condition codes from the isa table
    function automatic logic condMet(input logic [3:0] cc, input pipePkg::flagsT p);
        case (cc)
            4'd0:  return p.z;
            4'd1:  return !p.z;
            4'd2:  return p.c;
            4'd3:  return !p.c;
            4'd4:  return p.l;
            4'd5:  return !p.l;
            4'd6:  return p.n;
            4'd7:  return !p.n;
            4'd8:  return p.f;
            4'd9:  return !p.f;
            4'd10: return !p.z && !p.l;
            4'd11: return p.z || p.l;
            4'd12: return !p.z && !p.n;
            4'd13: return p.z || p.n;
            4'd14: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // in-order instruction semantics
    //////////////////////////////////////////////////

    function automatic void predict(
        input  logic [15:0] w,
        input  logic        v,
        input  logic [15:0] d,
        input  logic [15:0] s,
        input  pipePkg::flagsT p,
        output logic        wr,
        output logic [15:0] res,
        output pipePkg::flagsT np
    );
        logic [3:0]  op, fn, rs;
        logic [15:0] zx, sx, b, amt;
        logic [16:0] sum;
        logic        arith, isSub, useC, isCmp, isLog, setAll;
        op = w[15:12];
        fn = w[7:4];
        rs = w[3:0];
        zx = {8'h00, w[7:0]};
        sx = {{8{w[7]}}, w[7:0]};
        wr = 1'b0;
        res = '0;
        np = p;
        arith = 1'b0;
        isSub = 1'b0;
        useC = 1'b0;
        isCmp = 1'b0;
        isLog = 1'b0;
        setAll = 1'b0;
        b = s; // second operand
        case (op)
            4'h0: begin
                wr = 1'b1;
                case (fn)
                    4'h1: begin res = d & s; isLog = 1'b1; end
                    4'h2: begin res = d | s; isLog = 1'b1; end
                    4'h3: begin res = d ^ s; isLog = 1'b1; end
                    4'h4: begin res = ~d; isLog = 1'b1; end
                    4'h5: begin arith = 1'b1; setAll = 1'b1; end
                    4'h6: begin arith = 1'b1; setAll = 1'b1; useC = 1'b1; end
                    4'h7: arith = 1'b1; // addu, flags untouched
                    4'h9: begin arith = 1'b1; setAll = 1'b1; isSub = 1'b1; end
                    4'hA: begin arith = 1'b1; setAll = 1'b1; isSub = 1'b1; useC = 1'b1; end
                    4'hB: begin isCmp = 1'b1; wr = 1'b0; end
                    4'hD: res = s;
                    4'hE: res = d * s;
                    4'hF: begin res = d & s; isLog = 1'b1; wr = 1'b0; end
                    default: wr = 1'b0;
                endcase
            end
            4'h1: begin res = d & zx; isLog = 1'b1; wr = 1'b1; end
            4'h2: begin res = d | zx; isLog = 1'b1; wr = 1'b1; end
            4'h3: begin res = d ^ zx; isLog = 1'b1; wr = 1'b1; end
            4'h4: begin
                if (fn == 4'hD) begin
                    res = {15'd0, condMet(rs, p)};
                    wr  = 1'b1;
                end
            end
            4'h5: begin b = sx; arith = 1'b1; setAll = 1'b1; wr = 1'b1; end
            4'h6: begin b = sx; arith = 1'b1; setAll = 1'b1; useC = 1'b1; wr = 1'b1; end
            4'h7: begin b = sx; arith = 1'b1; wr = 1'b1; end
            4'h8: begin
                wr  = 1'b1;
                amt = -s; // right amount for negative src
                case (fn)
                    4'h0, 4'h2: res = d << rs;
                    4'h1: res = d >> rs;
                    4'h3: res = $signed(d) >>> rs;
                    4'h4: res = s[15] ? d >> amt[3:0] : d << s[3:0];
                    4'h6: begin
                        if (s[15]) res = $signed(d) >>> amt[3:0];
                        else res = d << s[3:0];
                    end
                    default: wr = 1'b0;
                endcase
            end
            4'h9: begin b = sx; arith = 1'b1; setAll = 1'b1; isSub = 1'b1; wr = 1'b1; end
            4'hA: begin
                b = sx;
                arith = 1'b1;
                setAll = 1'b1;
                isSub = 1'b1;
                useC = 1'b1;
                wr = 1'b1;
            end
            4'hB: begin b = sx; isCmp = 1'b1; end
            4'hD: begin res = zx; wr = 1'b1; end
            4'hE: begin res = d * sx; wr = 1'b1; end
            4'hF: begin res = zx << 8; wr = 1'b1; end
            default: wr = 1'b0; // bcond
        endcase
        if (arith) begin
            sum = {1'b0, d} + {1'b0, (isSub ? ~b : b)} + (useC ? p.c : isSub);
            res = sum[15:0];
            if (setAll) begin
                np.c = sum[16];
                // overflow when same-signed inputs give other sign
                np.f = isSub ? (d[15] != b[15]) && (res[15] != d[15])
                             : (d[15] == b[15]) && (res[15] != d[15]);
                np.z = (res == 16'd0);
                np.n = res[15];
            end
        end
        if (isCmp) begin
            np.z = (d == b);
            np.l = (d < b);
            np.n = ($signed(d) < $signed(b));
        end
        if (isLog) np.z = (res == 16'd0);
        if (!v) begin
            wr = 1'b0;
            np = p;
        end
    endfunction

    always_comb begin
        predict(instr, instrValid, shadowRf[instr.rdest], shadowRf[instr.rsrc], shadowPsr,
                nxtWr, nxtRes, nxtPsr);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_N; i++) begin
                shadowRf[i] <= '0;
            end
            shadowPsr <= pipePkg::flagsT'(`PSR_RST);
            for (int i = 0; i < 3; i++) begin
                line[i] <= '{valid: 1'b0, addr: 4'd0, data: '0,
                             psr: pipePkg::flagsT'(`PSR_RST)};
            end
        end else begin
            line[0] <= '{valid: nxtWr, addr: instr.rdest, data: nxtRes, psr: nxtPsr};
            line[1] <= line[0];
            line[2] <= line[1]; // lines up with writeback
            if (nxtWr) shadowRf[instr.rdest] <= nxtRes;
            shadowPsr <= nxtPsr;
        end
    end

    //////////////////////////////////////////////////
    // checks at the writeback ports
    //////////////////////////////////////////////////

    aValid: assert property (@(posedge clk) disable iff (!arstN) wbValid == line[2].valid)
        else begin
            errCount++;
            $error("ERR %0t wbValid exp %b got %b", $time, $sampled(line[2].valid),
                   $sampled(wbValid));
        end

    aAddr: assert property (@(posedge clk) disable iff (!arstN)
            line[2].valid |-> wbAddr == line[2].addr)
        else begin
            errCount++;
            $error("ERR %0t wbAddr exp %h got %h", $time, $sampled(line[2].addr),
                   $sampled(wbAddr));
        end

    aData: assert property (@(posedge clk) disable iff (!arstN)
            line[2].valid |-> wbData == line[2].data)
        else begin
            errCount++;
            $error("ERR %0t wbData exp %h got %h", $time, $sampled(line[2].data),
                   $sampled(wbData));
        end

    aPsr: assert property (@(posedge clk) disable iff (!arstN) psr == line[2].psr)
        else begin
            errCount++;
            $error("ERR %0t psr exp %b got %b", $time, $sampled(line[2].psr), $sampled(psr));
        end

endmodule

bind execPipe execPipe_assert assertInst (.*);

//--- dv/execPipe_tb.sv
`timescale 1ns/1ps
`include "execPipe_config.svh"

module execPipe_tb;

    logic               clk;
    logic               arstN;
    logic               instrValid;
    isaPkg::instrT      instr;
    logic               wbValid;
    logic [3:0]         wbAddr;
    logic [`DATA_W-1:0] wbData;
    pipePkg::flagsT     psr;
    int                 seed = 55207;
    int                 timeouts = 0;
    int                 idle;
    int                 waited;

    execPipe execPipe_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // one word per cycle, 2 ns after the edge
    task automatic issue(input logic v, input logic [15:0] w);
        @(posedge clk);
        #2;
        instrValid = v;
        instr      = isaPkg::instrT'(w);
    endtask

    function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [3:0] fn, input logic [3:0] rs);
        return {op, rd, fn, rs};
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        instrValid = 1'b0;
        instr      = '0;
        arstN      = 1'b0;
        for (int i = 0; i < 16; i++) @(posedge clk); // reset window
        #2 arstN = 1'b1;

        for (int r = 0; r < 16; r++) begin
            issue(1'b1, {4'hD, 4'(r), 8'(r * 29 + 5)}); // movi seeds
        end
        // each reg op reads the one before, at distance one, two and three
        for (int gap = 0; gap < 3; gap++) begin
            for (int f = 0; f < 16; f++) begin
                issue(1'b1, encode(4'h0, 4'(f), 4'(f), 4'(f + 15)));
                for (int g = 0; g < gap; g++) issue(1'b0, 16'h0);
            end
        end
        // every major opcode in immediate form
        for (int op = 1; op < 16; op++) begin
            issue(1'b1, {4'(op), 4'(op), 8'(8'h80 + op * 7)});
            issue(1'b1, {4'(op), 4'(op), 8'(op * 5)});
        end
        // carry chain into addc and subc
        issue(1'b1, {4'hF, 4'd1, 8'hFF});        // lui r1
        issue(1'b1, encode(4'h0, 4'd1, 4'h5, 4'd1)); // add sets C
        issue(1'b1, encode(4'h0, 4'd2, 4'h6, 4'd3)); // addc
        issue(1'b1, encode(4'h0, 4'd3, 4'hA, 4'd4)); // subc
        issue(1'b1, {4'h6, 4'd4, 8'h7F});
        issue(1'b1, {4'hA, 4'd5, 8'h01});
        // scond across several flag states
        for (int k = 0; k < 4; k++) begin
            issue(1'b1, encode(4'h0, 4'(k), 4'hB, 4'(k + 5))); // cmp
            issue(1'b1, {4'h5, 4'(k + 8), 8'(k * 60)});  // addi
            for (int cc = 0; cc < 16; cc++) begin
                issue(1'b1, encode(4'h4, 4'(cc), 4'hD, 4'(cc)));
            end
        end
        // shifts by immediate and by register
        issue(1'b1, {4'h7, 4'd6, 8'hFD}); // r6 = r6 - 3 style amount
        issue(1'b1, {4'hD, 4'd6, 8'h00});
        issue(1'b1, {4'h5, 4'd6, 8'hFD}); // r6 = -3
        for (int fn = 0; fn < 4; fn++) begin
            for (int a = 1; a < 16; a += 5) begin
                issue(1'b1, {4'hF, 4'd5, 8'h96}); // negative r5 before each shift
                issue(1'b1, encode(4'h8, 4'd5, 4'(fn), 4'(a)));
            end
        end
        issue(1'b1, {4'hF, 4'd7, 8'hC3}); // top bit set in r7
        issue(1'b1, encode(4'h8, 4'd7, 4'h4, 4'd6));
        issue(1'b1, encode(4'h8, 4'd5, 4'h6, 4'd6));
        issue(1'b1, encode(4'h8, 4'd7, 4'h4, 4'd3));
        issue(1'b1, encode(4'h8, 4'd5, 4'h6, 4'd3));
        // jal, bcond, jcond and a dropped strobe
        issue(1'b1, encode(4'h4, 4'd2, 4'h8, 4'd1));
        issue(1'b1, encode(4'h4, 4'd2, 4'hC, 4'd1));
        issue(1'b1, encode(4'hC, 4'd2, 4'h3, 4'd1));
        issue(1'b0, encode(4'h0, 4'd2, 4'h5, 4'd2));

        for (int i = 0; i < 400; i++) begin
            issue(($unsigned($random(seed)) % 5) != 0, 16'($random(seed)));
        end
        issue(1'b0, 16'h0);

        // drain until the write port stays quiet
        idle   = 0;
        waited = 0;
        while (idle < 5 && waited < 40) begin
            @(posedge clk);
            idle   = wbValid ? 0 : idle + 1;
            waited = waited + 1;
        end
        if (idle < 5) begin
            timeouts++;
            $display("drain timeout, pipeline kept writing after input stopped");
        end

        $display("errors: %0d assertion failures, %0d timeouts",
                 execPipe_inst.assertInst.errCount, timeouts);
        if (execPipe_inst.assertInst.errCount == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        #500us;
        $display("watchdog expired, simulation did not reach its end");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- execPipe.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
design/aluDecoder.sv
design/stageReg.sv
design/operandRead.sv
alu/aluCore.sv
design/execPipe.sv
dv/execPipe_assert.sv
dv/execPipe_tb.sv
